//--- rom_load_params.svh
// widths and region codes of the ROM download map; codes assume the 25-bit layout below
`ifndef ROM_LOAD_PARAMS_SVH
`define ROM_LOAD_PARAMS_SVH

// bus widths
`define LOAD_ADDR_W 25
`define SRAM_ADDR_W 17
`define SDRAM_ADDR_W 23
`define ROM_ADDR_W 15
// bytes kept behind the current one
`define ACC_BYTES 7

// main program banks in SRAM, matched on addr[24:16]
`define SRAM_BANK0_CODE 9'h041
`define SRAM_BANK1_CODE 9'h042
`define SRAM_BANK2_CODE 9'h045
`define SRAM_BANK3_CODE 9'h046

// 16-bit on-chip ROMs
`define ROM0_CODE 10'h080
`define ROM7_CODE 9'h047
`define SLAP_CODE 10'h090

// 8-bit sound and alphanumeric ROMs, addr[24:14]
`define SND0_CODE 11'h122
`define SND1_CODE 11'h123
`define SND2_CODE 11'h124
`define ALPHA_CODE 11'h125

// PROMs and EPROM, addr[24:9]
`define COLOR_CODE 16'h24C0
`define REMAP_CODE 16'h24C1
`define EPROM_CODE 16'h24C2

// graphics lives where addr[24:22] is zero
`define GFX_CODE 3'h0

// address bits per ROM
`define ROM0_AW 14
`define ROM7_AW 15
`define SND_AW 14
`define PROM_AW 9

`endif

//--- rom_load_pkg.sv
// shared payload types of the load path; rom_id_e encodings are only meaningful inside this core
`default_nettype none

`include "rom_load_params.svh"

package rom_load_pkg;

	//////////////////////////////////////////////////////////////////////
	// payload types
	//////////////////////////////////////////////////////////////////////

	// one loader byte
	typedef logic [7:0] byte_t;

	// ROM and SRAM word
	typedef logic [15:0] word_t;

	// SDRAM write granule, eight bytes
	typedef logic [63:0] qword_t;

	// loader address, full download map
	typedef logic [`LOAD_ADDR_W-1:0] load_addr_t;

	//////////////////////////////////////////////////////////////////////
	// on-chip ROM targets
	//////////////////////////////////////////////////////////////////////

	// tag carried with rom_we
	typedef enum logic [3:0] {
		ROM_NONE,
		// 16-bit main cpu ROMs
		ROM_MAIN0,
		ROM_MAIN7,
		ROM_SLAP,
		// 8-bit sound ROMs
		ROM_SND0,
		ROM_SND1,
		ROM_SND2,
		// alphanumerics
		ROM_ALPHA,
		// 512-byte PROMs
		ROM_COLOR,
		ROM_REMAP,
		ROM_EPROM
	} rom_id_e;

endpackage

`default_nettype wire

//--- load_beat_if.sv
// one accepted loader byte with its predecessors; beat is a single-cycle strobe on clk_sys
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

interface load_beat_if;

	// strobe, one cycle per accepted byte
	logic beat;
	// address and byte of that beat
	rom_load_pkg::load_addr_t addr;
	rom_load_pkg::byte_t data;
	// earlier bytes, newest in [7:0]
	logic [`ACC_BYTES*8-1:0] history;

	// ingress side
	modport source (
		output beat,
		output addr,
		output data,
		output history
	);

	// decode and SDRAM queue
	modport sink (
		input beat,
		input addr,
		input data,
		input history
	);

endinterface

`default_nettype wire

//--- load_handshake.sv
// four-phase loader slave; one byte per req/ack cycle, loader must wait for ack low before next req
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

module load_handshake (
	input logic clk_sys,
	input logic arst_n,
	input logic load_req,
	input rom_load_pkg::load_addr_t load_addr,
	input rom_load_pkg::byte_t load_data,
	output logic load_ack,
	input logic queue_full,
	load_beat_if.source beat_out
);

	//////////////////////////////////////////////////////////////////////
	// handshake
	//////////////////////////////////////////////////////////////////////

	logic accept;
	logic beat_q;
	rom_load_pkg::load_addr_t addr_q;
	rom_load_pkg::byte_t data_q;
	logic [`ACC_BYTES*8-1:0] acc_q;

	// new request, previous cycle closed, queue has room
	assign accept = load_req & ~load_ack & ~queue_full;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			load_ack <= 1'b0;
			beat_q <= 1'b0;
		end else begin
			beat_q <= accept;
			if (accept) begin
				load_ack <= 1'b1;
			end else if (load_ack && !load_req) begin
				// loader released req, close the cycle
				load_ack <= 1'b0;
			end
		end
	end

	// capture of the accepted byte
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			addr_q <= load_addr;
			data_q <= load_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// byte accumulator
	//////////////////////////////////////////////////////////////////////

	// shifted in the beat cycle, so during a beat the
	// accumulator still holds only the bytes before it
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc_q <= '0;
		end else if (beat_q) begin
			acc_q <= {acc_q[(`ACC_BYTES-1)*8-1:0], data_q};
		end
	end

	// out to the consumers
	assign beat_out.beat = beat_q;
	assign beat_out.addr = addr_q;
	assign beat_out.data = data_q;
	assign beat_out.history = acc_q;

endmodule

`default_nettype wire

//--- rom_region_decode.sv
// region decode for SRAM banks and on-chip ROMs; 16-bit targets write only on odd addresses
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

module rom_region_decode (
	input logic clk_sys,
	input logic arst_n,
	load_beat_if.sink beat_in,
	output logic sram_we,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output rom_load_pkg::word_t sram_wdata,
	output logic rom_we,
	output rom_load_pkg::rom_id_e rom_id,
	output logic [`ROM_ADDR_W-1:0] rom_addr,
	output rom_load_pkg::word_t rom_wdata
);

	localparam int AW = `LOAD_ADDR_W;

	rom_load_pkg::load_addr_t a;
	logic sram_hit;
	logic [1:0] bank;
	rom_load_pkg::rom_id_e id_nxt;
	logic wide_nxt;
	logic [`ROM_ADDR_W-1:0] addr_nxt;
	rom_load_pkg::word_t word_nxt;

	assign a = beat_in.addr;
	// previous byte is the high half
	assign word_nxt = {beat_in.history[7:0], beat_in.data};

	//////////////////////////////////////////////////////////////////////
	// SRAM banks
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sram_hit = 1'b1;
		bank = 2'd0;
		case (a[AW-1:16])
			`SRAM_BANK0_CODE: bank = 2'd0;
			`SRAM_BANK1_CODE: bank = 2'd1;
			`SRAM_BANK2_CODE: bank = 2'd2;
			`SRAM_BANK3_CODE: bank = 2'd3;
			default: sram_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// on-chip ROMs
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		id_nxt = rom_load_pkg::ROM_NONE;
		wide_nxt = 1'b0;
		addr_nxt = '0;
		// word-wide main cpu ROMs
		if (a[AW-1:15] == `ROM0_CODE) begin
			id_nxt = rom_load_pkg::ROM_MAIN0;
			wide_nxt = 1'b1;
			addr_nxt = `ROM_ADDR_W'(a[`ROM0_AW:1]);
		end else if (a[AW-1:16] == `ROM7_CODE) begin
			id_nxt = rom_load_pkg::ROM_MAIN7;
			wide_nxt = 1'b1;
			addr_nxt = `ROM_ADDR_W'(a[`ROM7_AW:1]);
		end else if (a[AW-1:15] == `SLAP_CODE) begin
			id_nxt = rom_load_pkg::ROM_SLAP;
			wide_nxt = 1'b1;
			addr_nxt = `ROM_ADDR_W'(a[`ROM0_AW:1]);
		// byte-wide, 16K each
		end else if (a[AW-1:14] == `SND0_CODE) begin
			id_nxt = rom_load_pkg::ROM_SND0;
			addr_nxt = `ROM_ADDR_W'(a[`SND_AW-1:0]);
		end else if (a[AW-1:14] == `SND1_CODE) begin
			id_nxt = rom_load_pkg::ROM_SND1;
			addr_nxt = `ROM_ADDR_W'(a[`SND_AW-1:0]);
		end else if (a[AW-1:14] == `SND2_CODE) begin
			id_nxt = rom_load_pkg::ROM_SND2;
			addr_nxt = `ROM_ADDR_W'(a[`SND_AW-1:0]);
		end else if (a[AW-1:14] == `ALPHA_CODE) begin
			id_nxt = rom_load_pkg::ROM_ALPHA;
			addr_nxt = `ROM_ADDR_W'(a[`SND_AW-1:0]);
		// 512-byte proms
		end else if (a[AW-1:9] == `COLOR_CODE) begin
			id_nxt = rom_load_pkg::ROM_COLOR;
			addr_nxt = `ROM_ADDR_W'(a[`PROM_AW-1:0]);
		end else if (a[AW-1:9] == `REMAP_CODE) begin
			id_nxt = rom_load_pkg::ROM_REMAP;
			addr_nxt = `ROM_ADDR_W'(a[`PROM_AW-1:0]);
		end else if (a[AW-1:9] == `EPROM_CODE) begin
			id_nxt = rom_load_pkg::ROM_EPROM;
			addr_nxt = `ROM_ADDR_W'(a[`PROM_AW-1:0]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// write ports, one cycle after beat
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sram_we <= 1'b0;
			rom_we <= 1'b0;
		end else begin
			sram_we <= beat_in.beat & sram_hit & a[0];
			rom_we <= beat_in.beat & (id_nxt != rom_load_pkg::ROM_NONE) &
				(~wide_nxt | a[0]);
		end
	end

	// payload follows every beat
	always_ff @(posedge clk_sys) begin
		if (beat_in.beat) begin
			sram_addr <= {bank, a[15:1]};
			sram_wdata <= word_nxt;
			rom_id <= id_nxt;
			rom_addr <= addr_nxt;
			// byte ROMs get a zero upper half
			rom_wdata <= wide_nxt ? word_nxt : {8'h00, beat_in.data};
		end
	end

endmodule

`default_nettype wire

//--- sdram_qword_queue.sv
// single-entry graphics queue; the loader must stall while queue_full is high or a quad-word is lost
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

module sdram_qword_queue (
	input logic clk_sys,
	input logic arst_n,
	load_beat_if.sink beat_in,
	output logic queue_full,
	input logic sdram_ready,
	output logic sdram_we,
	output logic [`SDRAM_ADDR_W-1:0] sdram_addr,
	output rom_load_pkg::qword_t sdram_data
);

	localparam int AW = `LOAD_ADDR_W;

	logic capture;

	//////////////////////////////////////////////////////////////////////
	// capture
	//////////////////////////////////////////////////////////////////////

	// eighth byte of a graphics quad-word
	assign capture = beat_in.beat &
		(beat_in.addr[AW-1:22] == `GFX_CODE) &
		(beat_in.addr[2:0] == 3'b111);

	// oldest byte lands in the top
	always_ff @(posedge clk_sys) begin
		if (capture) begin
			sdram_data <= {beat_in.history, beat_in.data};
			sdram_addr <= {1'b0, beat_in.addr[AW-1:3]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// issue
	//////////////////////////////////////////////////////////////////////

	// strobe follows ready directly
	// held entry is already on the outputs
	assign sdram_we = queue_full & sdram_ready;

	// full from capture through the write cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			queue_full <= 1'b0;
		end else if (capture) begin
			queue_full <= 1'b1;
		end else if (sdram_we) begin
			queue_full <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rom_load_top.sv
// ROM download path on clk_sys; memories sit outside and must take a write in the strobe cycle
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

module rom_load_top (
	input logic clk_sys,
	input logic arst_n,
	// loader, four-phase
	input logic load_req,
	input rom_load_pkg::load_addr_t load_addr,
	input rom_load_pkg::byte_t load_data,
	output logic load_ack,
	// SDRAM write side
	input logic sdram_ready,
	output logic sdram_we,
	output logic [`SDRAM_ADDR_W-1:0] sdram_addr,
	output rom_load_pkg::qword_t sdram_data,
	// main program SRAM
	output logic sram_we,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output rom_load_pkg::word_t sram_wdata,
	// on-chip ROM write port
	output logic rom_we,
	output rom_load_pkg::rom_id_e rom_id,
	output logic [`ROM_ADDR_W-1:0] rom_addr,
	output rom_load_pkg::word_t rom_wdata
);

	// back-pressure from the graphics queue
	logic queue_full;

	// accepted bytes fan out to both consumers
	load_beat_if beat_bus ();

	load_handshake i_load_handshake (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.load_req(load_req),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_ack(load_ack),
		.queue_full(queue_full),
		.beat_out(beat_bus.source)
	);

	// SRAM banks and small ROMs
	rom_region_decode i_rom_region_decode (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.beat_in(beat_bus.sink),
		.sram_we(sram_we),
		.sram_addr(sram_addr),
		.sram_wdata(sram_wdata),
		.rom_we(rom_we),
		.rom_id(rom_id),
		.rom_addr(rom_addr),
		.rom_wdata(rom_wdata)
	);

	// graphics to SDRAM
	sdram_qword_queue i_sdram_qword_queue (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.beat_in(beat_bus.sink),
		.queue_full(queue_full),
		.sdram_ready(sdram_ready),
		.sdram_we(sdram_we),
		.sdram_addr(sdram_addr),
		.sdram_data(sdram_data)
	);

endmodule

`default_nettype wire

//--- rom_load_checker.sv
// reference model of the load map; samples on rising clk_sys and expects writes one cycle after ack
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

module rom_load_checker (
	input logic clk_sys,
	input logic arst_n,
	input logic load_req,
	input rom_load_pkg::load_addr_t load_addr,
	input rom_load_pkg::byte_t load_data,
	input logic load_ack,
	input logic sdram_ready,
	input logic sdram_we,
	input logic [`SDRAM_ADDR_W-1:0] sdram_addr,
	input rom_load_pkg::qword_t sdram_data,
	input logic sram_we,
	input logic [`SRAM_ADDR_W-1:0] sram_addr,
	input rom_load_pkg::word_t sram_wdata,
	input logic rom_we,
	input rom_load_pkg::rom_id_e rom_id,
	input logic [`ROM_ADDR_W-1:0] rom_addr,
	input rom_load_pkg::word_t rom_wdata,
	input logic run_done,
	output logic busy,
	output int error_total,
	output int bytes_seen
);

	int value_errs = 0;
	int missing_errs = 0;
	int protocol_errs = 0;
	logic reported = 1'b0;

	// address map, base and size in bytes
	int sram_base [4];
	int rom_base [10];
	int rom_size [10];
	rom_load_pkg::rom_id_e rom_tag [10];
	logic rom_wide [10];

	// model state
	logic [63:0] hist = '0;
	logic ack_prev = 1'b0;
	logic req_prev = 1'b0;
	logic full_now = 1'b0;
	logic full_last = 1'b0;
	// queue state in the cycle a byte was taken, two samples before ack is seen
	logic full_accept = 1'b0;
	logic sram_due = 1'b0;
	logic [`SRAM_ADDR_W-1:0] exp_sram_addr;
	rom_load_pkg::word_t exp_sram_data;
	logic rom_due = 1'b0;
	rom_load_pkg::rom_id_e exp_rom_id;
	logic [`ROM_ADDR_W-1:0] exp_rom_addr;
	rom_load_pkg::word_t exp_rom_data;
	logic [`SDRAM_ADDR_W-1:0] exp_addr_q [$];
	rom_load_pkg::qword_t exp_data_q [$];

	assign error_total = value_errs + missing_errs + protocol_errs;

	task automatic add_rom(input int i, input int base, input int size,
		input rom_load_pkg::rom_id_e id, input logic wide);
		rom_base[i] = base;
		rom_size[i] = size;
		rom_tag[i] = id;
		rom_wide[i] = wide;
	endtask

	initial begin
		bytes_seen = 0;
		busy = 1'b0;
		sram_base[0] = 'h410000;
		sram_base[1] = 'h420000;
		sram_base[2] = 'h450000;
		sram_base[3] = 'h460000;
		// word ROMs
		add_rom(0, 'h400000, 'h8000, rom_load_pkg::ROM_MAIN0, 1'b1);
		add_rom(1, 'h470000, 'h10000, rom_load_pkg::ROM_MAIN7, 1'b1);
		add_rom(2, 'h480000, 'h8000, rom_load_pkg::ROM_SLAP, 1'b1);
		// byte ROMs and PROMs
		add_rom(3, 'h488000, 'h4000, rom_load_pkg::ROM_SND0, 1'b0);
		add_rom(4, 'h48C000, 'h4000, rom_load_pkg::ROM_SND1, 1'b0);
		add_rom(5, 'h490000, 'h4000, rom_load_pkg::ROM_SND2, 1'b0);
		add_rom(6, 'h494000, 'h4000, rom_load_pkg::ROM_ALPHA, 1'b0);
		add_rom(7, 'h498000, 'h200, rom_load_pkg::ROM_COLOR, 1'b0);
		add_rom(8, 'h498200, 'h200, rom_load_pkg::ROM_REMAP, 1'b0);
		add_rom(9, 'h498400, 'h200, rom_load_pkg::ROM_EPROM, 1'b0);
	end

	task automatic compare_hex(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			value_errs++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic note_fault(input logic missing, input string msg);
		if (missing)
			missing_errs++;
		else
			protocol_errs++;
		$display("%s at %0t", msg, $time);
	endtask

	//////////////////////////////////////////////////////////////////////
	// expected writes of one accepted byte
	//////////////////////////////////////////////////////////////////////

	task automatic model_byte(input rom_load_pkg::load_addr_t a, input rom_load_pkg::byte_t d);
		int ai;
		int i;
		rom_load_pkg::byte_t prev;
		ai = int'(a);
		prev = hist[7:0];
		hist = {hist[55:0], d};
		bytes_seen++;
		// SRAM, words close on the odd byte
		for (i = 0; i < 4; i++) begin
			if (ai >= sram_base[i] && ai < sram_base[i] + 'h10000 && a[0]) begin
				sram_due = 1'b1;
				exp_sram_addr = 17'((i << 15) + ((ai - sram_base[i]) >> 1));
				exp_sram_data = {prev, d};
			end
		end
		for (i = 0; i < 10; i++) begin
			if (ai >= rom_base[i] && ai < rom_base[i] + rom_size[i] &&
				(!rom_wide[i] || a[0])) begin
				rom_due = 1'b1;
				exp_rom_id = rom_tag[i];
				exp_rom_addr = rom_wide[i] ? 15'((ai - rom_base[i]) >> 1) :
					15'(ai - rom_base[i]);
				exp_rom_data = rom_wide[i] ? {prev, d} : {8'h00, d};
			end
		end
		// graphics, last byte of a quad-word
		if (ai < 'h400000 && a[2:0] == 3'b111) begin
			exp_addr_q.push_back(23'(ai >> 3));
			exp_data_q.push_back(hist);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// per-cycle compare
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		if (!arst_n) begin
			if (load_ack || sram_we || rom_we || sdram_we)
				note_fault(1'b0, "outputs not idle during reset");
			hist = '0;
			ack_prev = 1'b0;
			req_prev = 1'b0;
			full_last = 1'b0;
			full_accept = 1'b0;
			sram_due = 1'b0;
			rom_due = 1'b0;
			exp_addr_q.delete();
			exp_data_q.delete();
		end else begin
			// queue state before this edge
			full_now = (exp_addr_q.size() != 0);
			if (sram_due && !sram_we) begin
				note_fault(1'b1, "SRAM write missing one cycle after the byte");
			end else if (sram_we && !sram_due) begin
				note_fault(1'b0, "SRAM write without a matching byte");
			end else if (sram_we) begin
				compare_hex("sram_addr", 64'(exp_sram_addr), 64'(sram_addr));
				compare_hex("sram_wdata", 64'(exp_sram_data), 64'(sram_wdata));
			end
			sram_due = 1'b0;
			if (rom_due && !rom_we) begin
				note_fault(1'b1, "ROM write missing one cycle after the byte");
			end else if (rom_we && !rom_due) begin
				note_fault(1'b0, "ROM write without a matching byte");
			end else if (rom_we) begin
				compare_hex("rom_id", 64'(exp_rom_id), 64'(rom_id));
				compare_hex("rom_addr", 64'(exp_rom_addr), 64'(rom_addr));
				compare_hex("rom_wdata", 64'(exp_rom_data), 64'(rom_wdata));
			end
			rom_due = 1'b0;
			// SDRAM queue
			if (sdram_we && !sdram_ready)
				note_fault(1'b0, "SDRAM write while sdram_ready low");
			if (sdram_we) begin
				if (!full_now) begin
					note_fault(1'b0, "SDRAM write with no quad-word pending");
				end else begin
					compare_hex("sdram_addr", 64'(exp_addr_q[0]), 64'(sdram_addr));
					compare_hex("sdram_data", exp_data_q[0], sdram_data);
					void'(exp_addr_q.pop_front());
					void'(exp_data_q.pop_front());
				end
			end else if (full_now && sdram_ready) begin
				// retire the missed entry
				note_fault(1'b1, "SDRAM write held back while sdram_ready high");
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
			end
			// four-phase rules
			if (load_ack && !ack_prev) begin
				if (!req_prev)
					note_fault(1'b0, "load_ack rose without load_req");
				if (full_accept)
					note_fault(1'b0, "byte accepted while the SDRAM queue was full");
				model_byte(load_addr, load_data);
			end
			if (!load_ack && ack_prev && req_prev)
				note_fault(1'b0, "load_ack fell while load_req still high");
			ack_prev = load_ack;
			req_prev = load_req;
			full_accept = full_last;
			full_last = full_now;
			if (run_done && !reported) begin
				reported = 1'b1;
				$display("checker: %0d bytes, %0d value errors, %0d missing, %0d protocol errors",
					bytes_seen, value_errs, missing_errs, protocol_errs);
			end
		end
		busy = sram_due || rom_due || exp_addr_q.size() != 0;
	end

endmodule

`default_nettype wire

//--- tb_rom_load.sv
// self-checking testbench; fixed LFSR seed, the loader waits for each ack, run ends on drain or timeout
`timescale 1ns/1ps
`default_nettype none

`include "rom_load_params.svh"

module tb_rom_load;

	//////////////////////////////////////////////////////////////////////
	// run length and timeout budget
	//////////////////////////////////////////////////////////////////////

	localparam int RESET_CYCLES = 5;
	localparam int N_BURSTS = 40;
	localparam int BURST_LEN = 16;
	localparam int TOTAL_BYTES = N_BURSTS * BURST_LEN;
	// req to ack low, worst case without back-pressure
	localparam int HS_WORST = 4;
	// longest ready-low stretch plus the write cycle
	localparam int STALL_WORST = 16;
	localparam int CYCLE_LIMIT = 2 * TOTAL_BYTES * HS_WORST +
		(TOTAL_BYTES / 8) * STALL_WORST + RESET_CYCLES;

	logic clk_sys = 1'b0;
	logic arst_n;
	logic load_req;
	rom_load_pkg::load_addr_t load_addr;
	rom_load_pkg::byte_t load_data;
	logic load_ack;
	logic sdram_ready;
	logic sdram_we;
	logic [`SDRAM_ADDR_W-1:0] sdram_addr;
	rom_load_pkg::qword_t sdram_data;
	logic sram_we;
	logic [`SRAM_ADDR_W-1:0] sram_addr;
	rom_load_pkg::word_t sram_wdata;
	logic rom_we;
	rom_load_pkg::rom_id_e rom_id;
	logic [`ROM_ADDR_W-1:0] rom_addr;
	rom_load_pkg::word_t rom_wdata;

	// checker side
	logic run_done;
	logic checker_busy;
	int error_total;
	int bytes_seen;
	int bytes_sent = 0;
	int cycle_count = 0;

	// two streams, same seed
	logic [31:0] data_state = 32'd47;
	logic [31:0] ready_state = 32'd47;

	always #5 clk_sys = ~clk_sys;

	rom_load_top i_rom_load_top (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.load_req(load_req),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_ack(load_ack),
		.sdram_ready(sdram_ready),
		.sdram_we(sdram_we),
		.sdram_addr(sdram_addr),
		.sdram_data(sdram_data),
		.sram_we(sram_we),
		.sram_addr(sram_addr),
		.sram_wdata(sram_wdata),
		.rom_we(rom_we),
		.rom_id(rom_id),
		.rom_addr(rom_addr),
		.rom_wdata(rom_wdata)
	);

	rom_load_checker i_rom_load_checker (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.load_req(load_req),
		.load_addr(load_addr),
		.load_data(load_data),
		.load_ack(load_ack),
		.sdram_ready(sdram_ready),
		.sdram_we(sdram_we),
		.sdram_addr(sdram_addr),
		.sdram_data(sdram_data),
		.sram_we(sram_we),
		.sram_addr(sram_addr),
		.sram_wdata(sram_wdata),
		.rom_we(rom_we),
		.rom_id(rom_id),
		.rom_addr(rom_addr),
		.rom_wdata(rom_wdata),
		.run_done(run_done),
		.busy(checker_busy),
		.error_total(error_total),
		.bytes_seen(bytes_seen)
	);

	//////////////////////////////////////////////////////////////////////
	// random source
	//////////////////////////////////////////////////////////////////////

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one step per bit taken
	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val = {val[30:0], state[0]};
			state = lfsr_next(state);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// burst regions
	//////////////////////////////////////////////////////////////////////

	// 0..15 fixed regions, anything above is graphics
	task automatic region_pick(input int r, output int base, output int mask);
		case (r)
			0: base = 'h410000;
			1: base = 'h420000;
			2: base = 'h450000;
			3: base = 'h460000;
			4: base = 'h400000;
			5: base = 'h470000;
			6: base = 'h480000;
			7: base = 'h488000;
			8: base = 'h48C000;
			9: base = 'h490000;
			10: base = 'h494000;
			11: base = 'h498000;
			12: base = 'h498200;
			13: base = 'h498400;
			// holes in the map, no write expected
			14: base = 'h4A0000;
			15: base = 'h1800000;
			default: base = 'h000000;
		endcase
		// offset range inside the region
		case (r)
			0, 1, 2, 3, 5, 14, 15: mask = 'hFFFF;
			4, 6: mask = 'h7FFF;
			7, 8, 9, 10: mask = 'h3FFF;
			11, 12, 13: mask = 'h1FF;
			default: mask = 'h3FFFFF;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// loader, four-phase master
	//////////////////////////////////////////////////////////////////////

	task automatic send_byte(input rom_load_pkg::load_addr_t a, input rom_load_pkg::byte_t d);
		load_addr = a;
		load_data = d;
		load_req = 1'b1;
		bytes_sent++;
		// wait for ack, may stall behind the graphics queue
		do begin
			@(posedge clk_sys);
			#1;
		end while (!load_ack);
		load_req = 1'b0;
		// ack low closes the cycle
		do begin
			@(posedge clk_sys);
			#1;
		end while (load_ack);
	endtask

	// ready toggles in stretches, low 0..15, high 1..4
	initial begin
		logic [31:0] v;
		sdram_ready = 1'b0;
		wait (arst_n);
		forever begin
			take_bits(ready_state, 4, v);
			repeat (v) begin
				@(posedge clk_sys);
				#1;
				sdram_ready = 1'b0;
			end
			take_bits(ready_state, 2, v);
			repeat (v + 1) begin
				@(posedge clk_sys);
				#1;
				sdram_ready = 1'b1;
			end
		end
	end

	// main sequence
	initial begin
		logic [31:0] v;
		int b;
		int k;
		int base;
		int mask;
		int off;
		arst_n = 1'b0;
		load_req = 1'b0;
		load_addr = '0;
		load_data = '0;
		run_done = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
		for (b = 0; b < N_BURSTS; b++) begin
			take_bits(data_state, 5, v);
			region_pick(int'(v), base, mask);
			// offset aligned to the burst
			take_bits(data_state, 22, v);
			off = int'(v) & mask & ~15;
			for (k = 0; k < BURST_LEN; k++) begin
				take_bits(data_state, 8, v);
				send_byte(25'(base + off + k), v[7:0]);
			end
		end
		// let the last writes land
		while (checker_busy) begin
			@(posedge clk_sys);
			#1;
		end
		run_done = 1'b1;
		@(posedge clk_sys);
		#1;
		if (error_total == 0 && bytes_seen == bytes_sent) begin
			$display("All checks passed");
		end else begin
			if (bytes_seen != bytes_sent)
				$display("accepted %0d bytes but the loader sent %0d", bytes_seen, bytes_sent);
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the load did not complete", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
rom_load_pkg.sv
load_beat_if.sv
load_handshake.sv
rom_region_decode.sv
sdram_qword_queue.sv
rom_load_top.sv
rom_load_checker.sv
tb_rom_load.sv

//--- run.sh
#!/bin/sh
# build and run the ROM load testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_rom_load -o sim_rom_load

out=$(./obj_dir/sim_rom_load)
echo "$out"

if echo "$out" | grep -q "^All checks passed$"; then
	exit 0
else
	exit 1
fi
